//--- logic/icache_geom_pkg.sv
/*
  Geometry of the instruction cache tag side.
  Fixed at 256 sets, 16-byte lines and a 32-bit byte address.
  num_sets must stay a power of two equal to 2**index_w.
  A tag entry is one valid bit above the 20-bit tag.
*/
`default_nettype none

package icache_geom_pkg;

    localparam int num_sets = 256;      // sets per way
    localparam int index_w  = 8;        // log2(num_sets)
    localparam int offset_w = 4;        // byte offset in a 16-byte line
    localparam int tag_w    = 20;       // 32 - index_w - offset_w
    localparam int entry_w  = 21;       // valid + tag

    // byte address as seen by the cache
    typedef struct packed {
        logic [tag_w-1:0]    tag;       // upper bits, stored in the tag ram
        logic [index_w-1:0]  index;     // set select
        logic [offset_w-1:0] offset;    // ignored by the tag side
    } iaddr_t;

    // one stored tag entry, all zero means invalid
    typedef struct packed {
        logic             valid;        // entry holds a line
        logic [tag_w-1:0] tag;          // tag of that line
    } tag_entry_t;

endpackage

`default_nettype wire

//--- logic/icache_ctrl_pkg.sv
/*
  Controller types of the tag lookup and fill logic.
  way_e values match the lru bit: 1 names way 1 as next victim.
  Request and response structs carry no handshake of their own,
  they travel next to a plain strobe.
*/
`default_nettype none

package icache_ctrl_pkg;

    typedef enum logic [0:0] {
        way0 = 1'b0,
        way1 = 1'b1
    } way_e;

    typedef enum logic [1:0] {
        st_init = 2'd0,                 // reset sweep, invalidates all sets
        st_run  = 2'd1,                 // accepting lookups and fills
        st_fill = 2'd2                  // one write cycle, ready low
    } ctrl_state_e;

    typedef struct packed {
        icache_geom_pkg::iaddr_t addr;  // fetch address to check
    } lookup_req_t;

    typedef struct packed {
        logic hit;                      // tag found in a valid way
        way_e hit_way;                  // way0 wins if both match
        way_e victim_way;               // where a refill should go
    } lookup_resp_t;

    typedef struct packed {
        icache_geom_pkg::iaddr_t addr;  // line being refilled
        way_e                    way;   // target way, usually the victim
    } fill_req_t;

endpackage

`default_nettype wire

//--- logic/sync_sram.sv
/*
  Single-port synchronous RAM, one read or write per cycle.
  q is registered and holds its value while rden is low.
  Read during write of the same word is not defined here,
  callers keep the two apart.
  depth must be a power of two.
*/
`timescale 1ns/1ps
`default_nettype none

module sync_sram #(
    parameter int width = 8,
    parameter int depth = 256
) (
    input  logic                     clk,
    input  logic [$clog2(depth)-1:0] address,
    input  logic [width-1:0]         data,
    input  logic                     wren,
    input  logic                     rden,
    output logic [width-1:0]         q
);

    logic [width-1:0] mem [depth];      // storage, no reset

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[address] <= data;       // write port
        end
    end

    // registered read, like the vendor block rams
    always_ff @(posedge clk) begin
        if (rden) begin
            q <= mem[address];
        end
    end

endmodule

`default_nettype wire

//--- logic/itag_ram.sv
/*
  Tag store: two tag ways and one lru bit per set.
  lru is written on every way write and never on a hit.
  lru = 1 means way 1 is next to replace.
  A write to both ways at once (reset sweep) leaves lru at 1.
  Completion pulses come one cycle after the enables.
*/
`timescale 1ns/1ps
`default_nettype none

module itag_ram (
    input  logic                                clk,
    input  logic                                block0_we,   // write way 0
    input  logic                                block1_we,   // write way 1
    input  logic                                block0_re,   // read way 0
    input  logic                                block1_re,   // read way 1
    input  logic [icache_geom_pkg::index_w-1:0] index,
    input  icache_geom_pkg::tag_entry_t         tag_wd,
    output icache_geom_pkg::tag_entry_t         tag0_rd,
    output icache_geom_pkg::tag_entry_t         tag1_rd,
    output logic                                lru,
    output logic                                w_complete,
    output logic                                r_complete
);

    logic lru_we;                       // any way written
    logic lru_wd;                       // next victim after this write
    logic lru_re;                       // any way read

    assign lru_we = block0_we | block1_we;
    assign lru_wd = block0_we;          // way0 written -> way1 is older
    assign lru_re = block0_re | block1_re;

    always_ff @(posedge clk) begin
        w_complete <= block0_we | block1_we;
        r_complete <= block0_re | block1_re;    // data valid with this pulse
    end

    sync_sram #(
        .width (1),
        .depth (icache_geom_pkg::num_sets)
    ) lru_field (
        .clk     (clk),
        .address (index),
        .data    (lru_wd),
        .wren    (lru_we),
        .rden    (lru_re),
        .q       (lru)
    );

    sync_sram #(
        .width (icache_geom_pkg::entry_w),
        .depth (icache_geom_pkg::num_sets)
    ) tag_way0 (
        .clk     (clk),
        .address (index),
        .data    (tag_wd),
        .wren    (block0_we),
        .rden    (block0_re),
        .q       (tag0_rd)
    );

    sync_sram #(
        .width (icache_geom_pkg::entry_w),
        .depth (icache_geom_pkg::num_sets)
    ) tag_way1 (
        .clk     (clk),
        .address (index),
        .data    (tag_wd),
        .wren    (block1_we),
        .rden    (block1_re),
        .q       (tag1_rd)
    );

endmodule

`default_nettype wire

//--- logic/itag_lookup.sv
/*
  Lookup and fill controller for the tag store.
  After reset it invalidates one set per cycle, ready rises after 256 cycles.
  Lookups return resp_valid exactly 2 cycles after acceptance, in order.
  A fill holds ready low for one cycle and gives fill_done 1 cycle later.
  Strobes seen while ready is low are dropped. A fill wins over a lookup.
  Results cannot be stalled.
*/
`timescale 1ns/1ps
`default_nettype none

module itag_lookup (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                lookup_valid,
    input  icache_ctrl_pkg::lookup_req_t        lookup,
    input  logic                                fill_valid,
    input  icache_ctrl_pkg::fill_req_t          fill,
    output logic                                ready,
    output logic                                resp_valid,
    output icache_ctrl_pkg::lookup_resp_t       resp,
    output logic                                fill_done,
    output logic                                block0_we,
    output logic                                block1_we,
    output logic                                block0_re,
    output logic                                block1_re,
    output logic [icache_geom_pkg::index_w-1:0] index,
    output icache_geom_pkg::tag_entry_t         tag_wd,
    input  icache_geom_pkg::tag_entry_t         tag0_rd,
    input  icache_geom_pkg::tag_entry_t         tag1_rd,
    input  logic                                lru,
    input  logic                                w_complete,
    input  logic                                r_complete
);

    localparam int last_set = icache_geom_pkg::num_sets - 1;

    icache_ctrl_pkg::ctrl_state_e          state;
    logic [icache_geom_pkg::index_w-1:0]   sweep_cnt;    // set being invalidated
    icache_ctrl_pkg::fill_req_t            fill_q;       // accepted fill
    logic                                  fill_wr_q;    // write last cycle was a fill
    logic                                  lk_valid_q;   // stage 0: read in flight
    logic [icache_geom_pkg::tag_w-1:0]     lk_tag_q;     // stage 0 tag
    logic [icache_geom_pkg::index_w-1:0]   lk_index_q;   // stage 0 set
    logic [icache_geom_pkg::tag_w-1:0]     cmp_tag_q;    // stage 1 tag, meets ram data
    logic                                  hit0;
    logic                                  hit1;
    icache_ctrl_pkg::way_e                 victim;

    assign ready     = (state == icache_ctrl_pkg::st_run);
    assign fill_done = w_complete & fill_wr_q;   // sweep writes give no pulse

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= icache_ctrl_pkg::st_init;
            sweep_cnt  <= '0;
            lk_valid_q <= 1'b0;
            fill_wr_q  <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            case (state)
                icache_ctrl_pkg::st_init: begin
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (sweep_cnt == last_set[icache_geom_pkg::index_w-1:0]) begin
                        state <= icache_ctrl_pkg::st_run;   // all sets cleared
                    end
                end
                icache_ctrl_pkg::st_run: begin
                    if (fill_valid) begin
                        state <= icache_ctrl_pkg::st_fill;
                    end
                end
                icache_ctrl_pkg::st_fill: state <= icache_ctrl_pkg::st_run;
                default:                  state <= icache_ctrl_pkg::st_init;
            endcase
            lk_valid_q <= ready & lookup_valid & ~fill_valid;  // fill wins
            fill_wr_q  <= (state == icache_ctrl_pkg::st_fill);
            resp_valid <= r_complete;                          // compare takes one stage
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (ready && fill_valid) begin
            fill_q <= fill;
        end
        lk_tag_q   <= lookup.addr.tag;
        lk_index_q <= lookup.addr.index;
        cmp_tag_q  <= lk_tag_q;                 // lines up with r_complete
        if (r_complete) begin
            resp.hit        <= hit0 | hit1;
            resp.hit_way    <= hit0 ? icache_ctrl_pkg::way0 : icache_ctrl_pkg::way1;
            resp.victim_way <= victim;
        end
    end

    // ram side: sweep, fill write or lookup read, never two at once
    always_comb begin
        block0_we  = 1'b0;
        block1_we  = 1'b0;
        block0_re  = 1'b0;
        block1_re  = 1'b0;
        index      = lk_index_q;
        tag_wd     = '0;                        // invalid entry
        case (state)
            icache_ctrl_pkg::st_init: begin
                block0_we = 1'b1;               // both ways, lru ends at 1
                block1_we = 1'b1;
                index     = sweep_cnt;
            end
            icache_ctrl_pkg::st_fill: begin
                block0_we  = (fill_q.way == icache_ctrl_pkg::way0);
                block1_we  = (fill_q.way == icache_ctrl_pkg::way1);
                index      = fill_q.addr.index;
                tag_wd.valid = 1'b1;
                tag_wd.tag   = fill_q.addr.tag;
            end
            default: begin
                block0_re = lk_valid_q;         // read both ways of the set
                block1_re = lk_valid_q;
            end
        endcase
    end

    // tag compare, way0 first
    assign hit0 = tag0_rd.valid && (tag0_rd.tag == cmp_tag_q);
    assign hit1 = tag1_rd.valid && (tag1_rd.tag == cmp_tag_q);

    // victim: first free way, else the lru choice
    always_comb begin
        if (!tag0_rd.valid) begin
            victim = icache_ctrl_pkg::way0;
        end else if (!tag1_rd.valid) begin
            victim = icache_ctrl_pkg::way1;
        end else begin
            victim = icache_ctrl_pkg::way_e'(lru);
        end
    end

endmodule

`default_nettype wire

//--- logic/icache_tag_top.sv
/*
  Tag side of a two-way instruction cache: controller plus tag store.
  No data array and no refill engine, fills come from outside.
  Wait for ready after reset, about 256 cycles.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_tag_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          lookup_valid,
    input  icache_ctrl_pkg::lookup_req_t  lookup,
    input  logic                          fill_valid,
    input  icache_ctrl_pkg::fill_req_t    fill,
    output logic                          ready,
    output logic                          resp_valid,
    output icache_ctrl_pkg::lookup_resp_t resp,
    output logic                          fill_done
);

    logic                                block0_we;
    logic                                block1_we;
    logic                                block0_re;
    logic                                block1_re;
    logic [icache_geom_pkg::index_w-1:0] index;
    icache_geom_pkg::tag_entry_t         tag_wd;
    icache_geom_pkg::tag_entry_t         tag0_rd;
    icache_geom_pkg::tag_entry_t         tag1_rd;
    logic                                lru;
    logic                                w_complete;
    logic                                r_complete;

    itag_lookup itag_lookup_inst (
        .clk          (clk),
        .reset        (reset),
        .lookup_valid (lookup_valid),
        .lookup       (lookup),
        .fill_valid   (fill_valid),
        .fill         (fill),
        .ready        (ready),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .fill_done    (fill_done),
        .block0_we    (block0_we),
        .block1_we    (block1_we),
        .block0_re    (block0_re),
        .block1_re    (block1_re),
        .index        (index),
        .tag_wd       (tag_wd),
        .tag0_rd      (tag0_rd),
        .tag1_rd      (tag1_rd),
        .lru          (lru),
        .w_complete   (w_complete),
        .r_complete   (r_complete)
    );

    itag_ram itag_ram_inst (
        .clk        (clk),
        .block0_we  (block0_we),
        .block1_we  (block1_we),
        .block0_re  (block0_re),
        .block1_re  (block1_re),
        .index      (index),
        .tag_wd     (tag_wd),
        .tag0_rd    (tag0_rd),
        .tag1_rd    (tag1_rd),
        .lru        (lru),
        .w_complete (w_complete),
        .r_complete (r_complete)
    );

endmodule

`default_nettype wire

//--- test/icache_tag_assert.sv
/*
  Concurrent checks on the lookup controller, bound into itag_lookup.
  Latencies count sampled edges. A lookup accepted at one edge is seen
  as resp_valid at the third and a fill as fill_done at the second.
  Ready stays low for the 256 edges of the sweep after reset falls.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_tag_assert (
    input logic clk,
    input logic reset,
    input logic ready,
    input logic lookup_valid,
    input logic fill_valid,
    input logic resp_valid,
    input logic fill_done,
    input logic block0_we,
    input logic block1_we,
    input logic block0_re,
    input logic block1_re
);

    logic lk_accept;                    // lookup taken this edge
    logic fill_accept;                  // fill taken this edge

    assign lk_accept   = ready & lookup_valid & ~fill_valid;
    assign fill_accept = ready & fill_valid;

    ready_low_in_init: assert property (@(posedge clk) disable iff (reset)
        ready |-> !$past(reset, 256))
        else $error("ready high during the reset sweep");

    resp_after_lookup: assert property (@(posedge clk) disable iff (reset)
        resp_valid == $past(lk_accept, 3))
        else $error("resp_valid not 2 cycles after an accepted lookup");

    done_after_fill: assert property (@(posedge clk) disable iff (reset)
        fill_done == $past(fill_accept, 2))
        else $error("fill_done not 1 cycle after an accepted fill");

    no_read_on_write: assert property (@(posedge clk) disable iff (reset)
        (block0_re | block1_re) |-> !(block0_we | block1_we) && $past(lk_accept))
        else $error("tag ram read during a write or without an accepted lookup");

endmodule

`default_nettype wire

//--- test/icache_tag_tb.sv
/*
  Directed testbench for the tag side of the two-way icache.
  Inputs change on the falling edge and outputs are sampled there too.
  A model of valid tags and the lru bit per set predicts every response.
  Responses are matched in order and each is due 2 cycles after acceptance.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_tag_tb;

    typedef struct packed {
        logic [31:0]           due;         // cycle count when resp_valid is seen
        logic [31:0]           addr;
        logic                  hit;
        icache_ctrl_pkg::way_e hit_way;
        icache_ctrl_pkg::way_e victim_way;
    } resp_exp_t;

    localparam int max_cycles = 5000;       // 272 for reset and sweep plus the tests

    logic                          clk = 1'b0;
    logic                          reset;
    logic                          lookup_valid;
    icache_ctrl_pkg::lookup_req_t  lookup;
    logic                          fill_valid;
    icache_ctrl_pkg::fill_req_t    fill;
    logic                          ready;
    logic                          resp_valid;
    icache_ctrl_pkg::lookup_resp_t resp;
    logic                          fill_done;

    logic                              mdl_valid [icache_geom_pkg::num_sets][2];
    logic [icache_geom_pkg::tag_w-1:0] mdl_tag   [icache_geom_pkg::num_sets][2];
    logic                              mdl_lru   [icache_geom_pkg::num_sets];
    resp_exp_t                         exp_q[$];    // lookups waiting for resp
    resp_exp_t                         mon_exp;
    logic [31:0]                       cycle_count = '0;
    int                                err_count = 0;
    int                                test_err_base;
    int                                tests_run = 0;
    int                                tests_failed = 0;

    always #2 clk = ~clk;                   // 4 ns period

    icache_tag_top icache_tag_top_inst (
        .clk          (clk),
        .reset        (reset),
        .lookup_valid (lookup_valid),
        .lookup       (lookup),
        .fill_valid   (fill_valid),
        .fill         (fill),
        .ready        (ready),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .fill_done    (fill_done)
    );

    bind itag_lookup icache_tag_assert icache_tag_assert_inst (
        .clk          (clk),
        .reset        (reset),
        .ready        (ready),
        .lookup_valid (lookup_valid),
        .fill_valid   (fill_valid),
        .resp_valid   (resp_valid),
        .fill_done    (fill_done),
        .block0_we    (block0_we),
        .block1_we    (block1_we),
        .block0_re    (block0_re),
        .block1_re    (block1_re)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 32'd1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run still going after %0d cycles", max_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        err_count++;
    endtask

    // responses checked in order on their exact due cycle
    always @(negedge clk) begin
        if (!reset && resp_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("ERROR at %0t: response with no lookup pending", $time);
                err_count++;
            end
            if (exp_q.size() != 0) begin
                mon_exp = exp_q.pop_front();
                assert (mon_exp.due == cycle_count) else report_mismatch($sformatf(
                    "addr %h answered at cycle %0d, due %0d", mon_exp.addr, cycle_count,
                    mon_exp.due));
                assert (resp.hit == mon_exp.hit && resp.victim_way == mon_exp.victim_way
                        && (!mon_exp.hit || resp.hit_way == mon_exp.hit_way))
                else report_mismatch($sformatf(
                    "addr %h got hit %0d way %0d victim %0d, want hit %0d way %0d victim %0d",
                    mon_exp.addr, resp.hit, resp.hit_way, resp.victim_way, mon_exp.hit,
                    mon_exp.hit_way, mon_exp.victim_way));
            end
        end else if (!reset && exp_q.size() != 0) begin
            assert (exp_q[0].due > cycle_count) else begin
                mon_exp = exp_q.pop_front();
                $display("ERROR at %0t: no response for lookup of %h", $time, mon_exp.addr);
                err_count++;
            end
        end
    end

    function automatic icache_geom_pkg::iaddr_t make_addr(
        input logic [icache_geom_pkg::tag_w-1:0]   tag,
        input logic [icache_geom_pkg::index_w-1:0] index
    );
        icache_geom_pkg::iaddr_t a;
        a.tag    = tag;
        a.index  = index;
        a.offset = 4'($urandom);            // offset never matters
        return a;
    endfunction

    // expected answer from the model with way0 first, then a free way, then lru
    function automatic resp_exp_t predict_resp(input icache_geom_pkg::iaddr_t a);
        resp_exp_t e;
        logic      h0;
        logic      h1;
        h0 = mdl_valid[a.index][0] && (mdl_tag[a.index][0] == a.tag);
        h1 = mdl_valid[a.index][1] && (mdl_tag[a.index][1] == a.tag);
        e.due     = cycle_count + 32'd3;    // accepted next edge plus 2 more edges
        e.addr    = a;
        e.hit     = h0 | h1;
        e.hit_way = h0 ? icache_ctrl_pkg::way0 : icache_ctrl_pkg::way1;
        if (!mdl_valid[a.index][0]) e.victim_way = icache_ctrl_pkg::way0;
        else if (!mdl_valid[a.index][1]) e.victim_way = icache_ctrl_pkg::way1;
        else e.victim_way = mdl_lru[a.index] ? icache_ctrl_pkg::way1 : icache_ctrl_pkg::way0;
        return e;
    endfunction

    task automatic wait_ready();
        while (!ready) @(negedge clk);
    endtask

    task automatic send_lookup(input icache_geom_pkg::iaddr_t a);
        wait_ready();
        lookup_valid = 1'b1;
        lookup.addr  = a;
        exp_q.push_back(predict_resp(a));
        @(negedge clk);
        lookup_valid = 1'b0;
    endtask

    task automatic send_fill(input icache_geom_pkg::iaddr_t a, input icache_ctrl_pkg::way_e w);
        wait_ready();
        fill_valid = 1'b1;
        fill.addr  = a;
        fill.way   = w;
        mdl_valid[a.index][w] = 1'b1;
        mdl_tag[a.index][w]   = a.tag;
        mdl_lru[a.index]      = (w == icache_ctrl_pkg::way0);  // other way is older
        @(negedge clk);
        fill_valid = 1'b0;
        assert (!fill_done && !ready) else report_mismatch($sformatf(
            "fill %h cycle 1 fill_done %0d ready %0d", a, fill_done, ready));
        @(negedge clk);
        assert (fill_done && ready) else report_mismatch($sformatf(
            "fill %h cycle 2 fill_done %0d ready %0d", a, fill_done, ready));
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_count != test_err_base) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - test_err_base);
        end else begin
            $display("test %s: ok", name);
        end
        test_err_base = err_count;
    endtask

    task automatic test_reset_sweep();
        int edges;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
            assert (!resp_valid && !fill_done) else report_mismatch("pulse during sweep");
        end while (!ready && edges < 400);
        assert (edges == 256) else report_mismatch($sformatf(
            "ready after %0d edges, want 256", edges));
        send_lookup(make_addr(20'h12345, 8'h00));   // all invalid so miss to way0
        send_lookup(make_addr(20'h00abc, 8'h01));
        send_lookup(make_addr(20'hfffff, 8'h5a));
        send_lookup(make_addr(20'h00000, 8'hff));
        drain();
        end_test("reset_sweep");
    endtask

    task automatic test_fill_hit();
        send_fill(make_addr(20'h12345, 8'h21), icache_ctrl_pkg::way0);
        send_lookup(make_addr(20'h12345, 8'h21));   // hit way0
        drain();
        send_lookup(make_addr(20'h54321, 8'h21));   // miss with way1 still free
        drain();
        end_test("fill_hit");
    endtask

    task automatic test_lru_victim();
        send_fill(make_addr(20'h54321, 8'h21), icache_ctrl_pkg::way1);
        send_lookup(make_addr(20'h12345, 8'h21));
        send_lookup(make_addr(20'h54321, 8'h21));
        send_lookup(make_addr(20'h0badc, 8'h21));   // set full so lru picks
        drain();
        send_fill(make_addr(20'h0badc, 8'h21), icache_ctrl_pkg::way0);
        send_lookup(make_addr(20'h0badc, 8'h21));
        send_lookup(make_addr(20'h12345, 8'h21));   // replaced so the victim flips
        send_lookup(make_addr(20'h54321, 8'h21));
        drain();
        end_test("lru_victim");
    endtask

    task automatic test_back_to_back();
        send_lookup(make_addr(20'h12345, 8'h21));
        send_lookup(make_addr(20'h54321, 8'h21));
        send_lookup(make_addr(20'h0badc, 8'h21));
        send_lookup(make_addr(20'h54321, 8'h22));   // other set still empty
        send_lookup(make_addr(20'h0badc, 8'h21));
        send_lookup(make_addr(20'h77777, 8'h21));
        send_lookup(make_addr(20'h54321, 8'h21));
        send_lookup(make_addr(20'h12345, 8'h00));
        drain();
        end_test("back_to_back");
    endtask

    task automatic test_random_mix();
        logic [icache_geom_pkg::tag_w-1:0]   tag_pool [4];
        logic [icache_geom_pkg::index_w-1:0] idx_pool [4];
        icache_geom_pkg::iaddr_t             a;
        tag_pool = '{20'h12345, 20'habcde, 20'h00001, 20'hfffff};
        idx_pool = '{8'h21, 8'h40, 8'h41, 8'hfe};
        for (int i = 0; i < 300; i++) begin
            a = make_addr(tag_pool[2'($urandom)], idx_pool[2'($urandom)]);
            if (2'($urandom) == 2'd0) begin
                send_fill(a, icache_ctrl_pkg::way_e'(1'($urandom)));
                if (1'($urandom)) send_lookup(a);   // read right after the write
            end else begin
                send_lookup(a);
            end
        end
        drain();
        end_test("random_mix");
    endtask

    initial begin
        void'($urandom(81756));
        reset        = 1'b1;
        lookup_valid = 1'b0;
        lookup       = '0;
        fill_valid   = 1'b0;
        fill         = '0;
        for (int s = 0; s < icache_geom_pkg::num_sets; s++) begin
            mdl_valid[s][0] = 1'b0;
            mdl_valid[s][1] = 1'b0;
            mdl_tag[s][0]   = '0;
            mdl_tag[s][1]   = '0;
            mdl_lru[s]      = 1'b1;         // sweep writes both ways
        end
        test_err_base = 0;
        test_reset_sweep();
        test_fill_hit();
        test_lru_victim();
        test_back_to_back();
        test_random_mix();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- icache_tag_top.f
logic/icache_geom_pkg.sv
logic/icache_ctrl_pkg.sv
logic/sync_sram.sv
logic/itag_ram.sv
logic/itag_lookup.sv
logic/icache_tag_top.sv
test/icache_tag_assert.sv
test/icache_tag_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the icache tag testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module icache_tag_tb \
    -f icache_tag_top.f \
    -o icache_tag_sim

./obj_dir/icache_tag_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
